/* vlog.f */
logic/udp_echo_pkg.sv
logic/udp_hdr_if.sv
logic/udp_payload_if.sv
logic/udp_port_filter.sv
logic/payload_fifo.sv
logic/udp_reply_tx.sv
logic/udp_echo_core.sv
verif/udp_echo_asserts.sv
verif/udp_echo_tb.sv

/* Makefile */
# Verilator build and run of the UDP echo testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module udp_echo_tb -f vlog.f
	@out="$$(./obj_dir/Vudp_echo_tb)"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

/* verif/udp_echo_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_echo_tb
    import udp_echo_pkg::*;
();

    localparam int NUM_FRAMES   = 40;
    localparam int MAX_BEATS    = 6;
    localparam int MAX_STALL    = 20;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int HOLD_CYCLES  = 3 * PAYLOAD_FIFO_DEPTH;
    localparam int WATCHDOG_NS  = NUM_FRAMES * MAX_BEATS * MAX_STALL * CLK_PERIOD
                                  + (RESET_CYCLES + HOLD_CYCLES) * CLK_PERIOD;

    localparam logic [31:0] LFSR_SEED = 32'h23b71793;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    typedef struct packed {
        logic [IP_WIDTH-1:0]   ip_dest_ip;
        logic [PORT_WIDTH-1:0] source_port;
        logic [PORT_WIDTH-1:0] dest_port;
        logic [PORT_WIDTH-1:0] length;
    } hdr_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] tdata;
        logic [KEEP_WIDTH-1:0] tkeep;
        logic                  tlast;
        logic                  tuser;
    } beat_t;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  rx_hdr_valid;
    logic                  rx_hdr_ready;
    logic [IP_WIDTH-1:0]   rx_ip_source_ip;
    logic [PORT_WIDTH-1:0] rx_source_port;
    logic [PORT_WIDTH-1:0] rx_dest_port;
    logic [PORT_WIDTH-1:0] rx_length;
    logic [DATA_WIDTH-1:0] rx_payload_tdata;
    logic [KEEP_WIDTH-1:0] rx_payload_tkeep;
    logic                  rx_payload_tvalid;
    logic                  rx_payload_tready;
    logic                  rx_payload_tlast;
    logic                  rx_payload_tuser;
    logic                  tx_hdr_valid;
    logic                  tx_hdr_ready;
    logic [IP_WIDTH-1:0]   tx_ip_dest_ip;
    logic [PORT_WIDTH-1:0] tx_source_port;
    logic [PORT_WIDTH-1:0] tx_dest_port;
    logic [PORT_WIDTH-1:0] tx_length;
    logic [DATA_WIDTH-1:0] tx_payload_tdata;
    logic [KEEP_WIDTH-1:0] tx_payload_tkeep;
    logic                  tx_payload_tvalid;
    logic                  tx_payload_tready;
    logic                  tx_payload_tlast;
    logic                  tx_payload_tuser;
    logic [LED_WIDTH-1:0]  led;

    hdr_t                  hdr_q[$];
    beat_t                 beat_q[$];
    logic [31:0]           main_lfsr;
    logic [31:0]           stall_lfsr;
    logic                  rx_pass;
    logic                  tvalid_prev;
    logic [LED_WIDTH-1:0]  led_expect;
    int                    held_beats;
    int                    value_errors = 0;
    int                    other_errors = 0;

    udp_echo_core dut0 (.*);

    bind udp_echo_core udp_echo_asserts u_asserts (
        .clk               (clk),
        .rst               (rst),
        .rx_dest_port      (rx_dest_port),
        .tx_hdr_valid      (tx_hdr_valid),
        .tx_payload_tdata  (tx_payload_tdata),
        .tx_payload_tkeep  (tx_payload_tkeep),
        .tx_payload_tvalid (tx_payload_tvalid),
        .tx_payload_tready (tx_payload_tready),
        .tx_payload_tlast  (tx_payload_tlast),
        .tx_payload_tuser  (tx_payload_tuser),
        .led               (led)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken, low bit first
    task automatic draw(inout logic [31:0] state, input int n, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value[i] = state[0];
            state = lfsr_step(state);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("FAIL %s expected %h got %h", name, expected, actual);
        value_errors++;
    endtask

    task automatic send_frame(input logic match, input int beats);
        logic [63:0]           r;
        beat_t                 frame [MAX_BEATS];
        logic [IP_WIDTH-1:0]   ip;
        logic [PORT_WIDTH-1:0] sport;
        logic [PORT_WIDTH-1:0] dport;
        int                    nbytes;
        draw(main_lfsr, 32, r);
        ip = r[IP_WIDTH-1:0];
        draw(main_lfsr, 16, r);
        sport = r[PORT_WIDTH-1:0];
        draw(main_lfsr, 16, r);
        dport = match ? ECHO_PORT : r[PORT_WIDTH-1:0];
        if (!match && dport == ECHO_PORT) begin
            dport = dport + PORT_WIDTH'(1);
        end
        nbytes = 0;
        for (int i = 0; i < beats; i++) begin
            draw(main_lfsr, 64, r);
            frame[i].tdata = r;
            frame[i].tlast = (i == beats - 1);
            draw(main_lfsr, 4, r);
            // Only the last beat may be partial
            frame[i].tkeep = frame[i].tlast ? ({KEEP_WIDTH{1'b1}} >> r[2:0]) : '1;
            frame[i].tuser = frame[i].tlast & r[3];
            nbytes += $countones(frame[i].tkeep);
        end
        if (match) begin
            hdr_q.push_back(hdr_t'{ip, ECHO_PORT, sport, PORT_WIDTH'(8 + nbytes)});
        end
        rx_hdr_valid    = 1'b1;
        rx_ip_source_ip = ip;
        rx_source_port  = sport;
        rx_dest_port    = dport;
        rx_length       = PORT_WIDTH'(8 + nbytes);
        @(posedge clk);
        while (!rx_hdr_ready) @(posedge clk);
        #1;
        rx_hdr_valid = 1'b0;
        rx_pass      = match;
        for (int i = 0; i < beats; i++) begin
            if (match) begin
                beat_q.push_back(frame[i]);
            end
            rx_payload_tvalid = 1'b1;
            rx_payload_tdata  = frame[i].tdata;
            rx_payload_tkeep  = frame[i].tkeep;
            rx_payload_tlast  = frame[i].tlast;
            rx_payload_tuser  = frame[i].tuser;
            @(posedge clk);
            while (!rx_payload_tready) @(posedge clk);
            #1;
        end
        rx_payload_tvalid = 1'b0;
        rx_pass           = 1'b0;
    endtask

    always @(posedge clk) begin
        hdr_t  exp_hdr;
        beat_t exp_beat;
        if (rst) begin
            led_expect  = '0;
            tvalid_prev = 1'b0;
            held_beats  = 0;
        end else begin
            assert (led == led_expect)
                else report_mismatch("led", 64'(led_expect), 64'(led));
            // LED takes the first byte of a new burst next cycle
            if (tx_payload_tvalid && !tvalid_prev && beat_q.size() != 0) begin
                led_expect = beat_q[0].tdata[LED_WIDTH-1:0];
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (hdr_q.size() == 0) begin
                    $display("Reply header sent with no echoed frame outstanding");
                    other_errors++;
                end else begin
                    exp_hdr = hdr_q.pop_front();
                    assert (tx_ip_dest_ip == exp_hdr.ip_dest_ip)
                        else report_mismatch("tx_ip_dest_ip", 64'(exp_hdr.ip_dest_ip),
                                             64'(tx_ip_dest_ip));
                    assert (tx_source_port == exp_hdr.source_port)
                        else report_mismatch("tx_source_port", 64'(exp_hdr.source_port),
                                             64'(tx_source_port));
                    assert (tx_dest_port == exp_hdr.dest_port)
                        else report_mismatch("tx_dest_port", 64'(exp_hdr.dest_port),
                                             64'(tx_dest_port));
                    assert (tx_length == exp_hdr.length)
                        else report_mismatch("tx_length", 64'(exp_hdr.length), 64'(tx_length));
                end
            end
            if (tx_payload_tvalid && tx_payload_tready) begin
                if (beat_q.size() == 0) begin
                    $display("Reply beat sent with no echoed beat outstanding");
                    other_errors++;
                end else begin
                    exp_beat = beat_q.pop_front();
                    assert (tx_payload_tdata == exp_beat.tdata)
                        else report_mismatch("tx_payload_tdata", exp_beat.tdata,
                                             tx_payload_tdata);
                    assert (tx_payload_tkeep == exp_beat.tkeep)
                        else report_mismatch("tx_payload_tkeep", 64'(exp_beat.tkeep),
                                             64'(tx_payload_tkeep));
                    assert (tx_payload_tlast == exp_beat.tlast)
                        else report_mismatch("tx_payload_tlast", 64'(exp_beat.tlast),
                                             64'(tx_payload_tlast));
                    assert (tx_payload_tuser == exp_beat.tuser)
                        else report_mismatch("tx_payload_tuser", 64'(exp_beat.tuser),
                                             64'(tx_payload_tuser));
                end
            end
            // Beats taken into the FIFO while the reply side is stalled
            if (tx_payload_tready) begin
                held_beats = 0;
            end else if (rx_payload_tvalid && rx_payload_tready && rx_pass) begin
                held_beats++;
            end
            assert (held_beats <= PAYLOAD_FIFO_DEPTH) else begin
                $display("Receive side took more beats than the FIFO holds during a stall");
                other_errors++;
            end
            tvalid_prev = tx_payload_tvalid;
        end
    end

    // Reply side ready pattern from its own LFSR stream
    initial begin
        logic [63:0] r;
        int          n;
        tx_hdr_ready      = 1'b0;
        tx_payload_tready = 1'b0;
        @(negedge rst);
        tx_hdr_ready = 1'b1;
        // Long stall at start so the FIFO fills up
        repeat (HOLD_CYCLES) @(posedge clk);
        #1;
        forever begin
            draw(stall_lfsr, 1, r);
            tx_payload_tready = r[0];
            draw(stall_lfsr, 5, r);
            n = r[0] ? int'(r[2:1]) + 1 : int'(r[4:0] % 5'd20) + 1;
            repeat (n) begin
                draw(stall_lfsr, 2, r);
                tx_hdr_ready = |r[1:0];
                @(posedge clk);
                #1;
            end
        end
    end

    initial begin
        logic [63:0] r;
        logic        match;
        int          beats;
        rst               = 1'b1;
        rx_hdr_valid      = 1'b0;
        rx_ip_source_ip   = '0;
        rx_source_port    = '0;
        rx_dest_port      = '0;
        rx_length         = '0;
        rx_payload_tdata  = '0;
        rx_payload_tkeep  = '0;
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast  = 1'b0;
        rx_payload_tuser  = 1'b0;
        rx_pass           = 1'b0;
        main_lfsr = LFSR_SEED;
        draw(main_lfsr, 32, r);
        stall_lfsr = r[31:0] | 32'h1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            draw(main_lfsr, 4, r);
            // First frames are full echoes that overrun the stalled FIFO
            match = (f < 4) || r[0];
            beats = (f < 4) ? MAX_BEATS : int'(r[3:1] % 3'd6) + 1;
            send_frame(match, beats);
        end
        while (hdr_q.size() != 0 || beat_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        $display("Summary: %0d frames, %0d value, %0d other, %0d assertion errors",
                 NUM_FRAMES, value_errors, other_errors, dut0.u_asserts.failures);
        if (value_errors == 0 && other_errors == 0 && dut0.u_asserts.failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Run did not finish before the watchdog expired");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/udp_echo_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_echo_asserts
    import udp_echo_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic [PORT_WIDTH-1:0] rx_dest_port,
    input logic                  tx_hdr_valid,
    input logic [DATA_WIDTH-1:0] tx_payload_tdata,
    input logic [KEEP_WIDTH-1:0] tx_payload_tkeep,
    input logic                  tx_payload_tvalid,
    input logic                  tx_payload_tready,
    input logic                  tx_payload_tlast,
    input logic                  tx_payload_tuser,
    input logic [LED_WIDTH-1:0]  led
);

    int failures = 0;

    // Replies only for the echo port
    hdr_port_check: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid |-> (rx_dest_port == ECHO_PORT))
        else begin
            $error("reply header raised for destination port %0d", rx_dest_port);
            failures++;
        end

    // Stalled beat must hold still
    payload_hold_check: assert property (@(posedge clk) disable iff (rst)
        (tx_payload_tvalid && !tx_payload_tready) |=>
            (tx_payload_tvalid && $stable(tx_payload_tdata) && $stable(tx_payload_tkeep)
             && $stable(tx_payload_tlast) && $stable(tx_payload_tuser)))
        else begin
            $error("tx payload changed while stalled");
            failures++;
        end

    // Clean outputs once reset is released
    reset_state_check: assert property (@(posedge clk)
        $fell(rst) |-> (led == '0 && !tx_payload_tvalid))
        else begin
            $error("led or tx_payload_tvalid not cleared by reset");
            failures++;
        end

endmodule

`default_nettype wire

/* logic/udp_echo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_echo_core
    import udp_echo_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // Parsed UDP frame in
    input  logic                  rx_hdr_valid,
    output logic                  rx_hdr_ready,
    input  logic [IP_WIDTH-1:0]   rx_ip_source_ip,
    input  logic [PORT_WIDTH-1:0] rx_source_port,
    input  logic [PORT_WIDTH-1:0] rx_dest_port,
    input  logic [PORT_WIDTH-1:0] rx_length,
    input  logic [DATA_WIDTH-1:0] rx_payload_tdata,
    input  logic [KEEP_WIDTH-1:0] rx_payload_tkeep,
    input  logic                  rx_payload_tvalid,
    output logic                  rx_payload_tready,
    input  logic                  rx_payload_tlast,
    input  logic                  rx_payload_tuser,

    // Reply frame out
    output logic                  tx_hdr_valid,
    input  logic                  tx_hdr_ready,
    output logic [IP_WIDTH-1:0]   tx_ip_dest_ip,
    output logic [PORT_WIDTH-1:0] tx_source_port,
    output logic [PORT_WIDTH-1:0] tx_dest_port,
    output logic [PORT_WIDTH-1:0] tx_length,
    output logic [DATA_WIDTH-1:0] tx_payload_tdata,
    output logic [KEEP_WIDTH-1:0] tx_payload_tkeep,
    output logic                  tx_payload_tvalid,
    input  logic                  tx_payload_tready,
    output logic                  tx_payload_tlast,
    output logic                  tx_payload_tuser,

    output logic [LED_WIDTH-1:0]  led
);

    udp_hdr_if     reply_hdr ();
    udp_payload_if filt_payload ();
    udp_payload_if fifo_payload ();

    udp_port_filter u_filter (
        .clk               (clk),
        .rst               (rst),
        .rx_hdr_valid      (rx_hdr_valid),
        .rx_hdr_ready      (rx_hdr_ready),
        .rx_ip_source_ip   (rx_ip_source_ip),
        .rx_source_port    (rx_source_port),
        .rx_dest_port      (rx_dest_port),
        .rx_length         (rx_length),
        .rx_payload_tdata  (rx_payload_tdata),
        .rx_payload_tkeep  (rx_payload_tkeep),
        .rx_payload_tvalid (rx_payload_tvalid),
        .rx_payload_tready (rx_payload_tready),
        .rx_payload_tlast  (rx_payload_tlast),
        .rx_payload_tuser  (rx_payload_tuser),
        .hdr_out           (reply_hdr.src),
        .payload_out       (filt_payload.src)
    );

    payload_fifo u_fifo (
        .clk         (clk),
        .rst         (rst),
        .payload_in  (filt_payload.dst),
        .payload_out (fifo_payload.src)
    );

    udp_reply_tx u_reply (
        .clk               (clk),
        .rst               (rst),
        .hdr_in            (reply_hdr.dst),
        .payload_in        (fifo_payload.dst),
        .tx_hdr_valid      (tx_hdr_valid),
        .tx_hdr_ready      (tx_hdr_ready),
        .tx_ip_dest_ip     (tx_ip_dest_ip),
        .tx_source_port    (tx_source_port),
        .tx_dest_port      (tx_dest_port),
        .tx_length         (tx_length),
        .tx_payload_tdata  (tx_payload_tdata),
        .tx_payload_tkeep  (tx_payload_tkeep),
        .tx_payload_tvalid (tx_payload_tvalid),
        .tx_payload_tready (tx_payload_tready),
        .tx_payload_tlast  (tx_payload_tlast),
        .tx_payload_tuser  (tx_payload_tuser),
        .led               (led)
    );

endmodule

`default_nettype wire

/* logic/udp_reply_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_reply_tx
    import udp_echo_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    udp_hdr_if.dst                hdr_in,
    udp_payload_if.dst            payload_in,

    output logic                  tx_hdr_valid,
    input  logic                  tx_hdr_ready,
    output logic [IP_WIDTH-1:0]   tx_ip_dest_ip,
    output logic [PORT_WIDTH-1:0] tx_source_port,
    output logic [PORT_WIDTH-1:0] tx_dest_port,
    output logic [PORT_WIDTH-1:0] tx_length,

    output logic [DATA_WIDTH-1:0] tx_payload_tdata,
    output logic [KEEP_WIDTH-1:0] tx_payload_tkeep,
    output logic                  tx_payload_tvalid,
    input  logic                  tx_payload_tready,
    output logic                  tx_payload_tlast,
    output logic                  tx_payload_tuser,

    output logic [LED_WIDTH-1:0]  led
);

    logic valid_prev;

    // Reply goes back to the sender, ports swapped
    assign tx_hdr_valid   = hdr_in.valid;
    assign hdr_in.ready   = tx_hdr_ready;
    assign tx_ip_dest_ip  = hdr_in.ip_source_ip;
    assign tx_source_port = hdr_in.dest_port;
    assign tx_dest_port   = hdr_in.source_port;
    assign tx_length      = hdr_in.length;

    // Echoed payload is sent unchanged
    assign tx_payload_tdata  = payload_in.tdata;
    assign tx_payload_tkeep  = payload_in.tkeep;
    assign tx_payload_tvalid = payload_in.tvalid;
    assign tx_payload_tlast  = payload_in.tlast;
    assign tx_payload_tuser  = payload_in.tuser;
    assign payload_in.tready = tx_payload_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_prev <= 1'b0;
            led        <= '0;
        end else begin
            valid_prev <= payload_in.tvalid;
            // Rising edge of valid marks the first beat of a burst
            if (payload_in.tvalid && !valid_prev) begin
                led <= payload_in.tdata[LED_WIDTH-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/payload_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module payload_fifo
    import udp_echo_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    udp_payload_if.dst payload_in,
    udp_payload_if.src payload_out
);

    logic [FIFO_ENTRY_WIDTH-1:0] mem [PAYLOAD_FIFO_DEPTH];

    logic [FIFO_PTR_WIDTH-1:0]   wr_ptr;
    logic [FIFO_PTR_WIDTH-1:0]   rd_ptr;
    logic [FIFO_COUNT_WIDTH-1:0] count;

    logic                        full;
    logic                        empty;
    logic                        wr_en;
    logic                        rd_en;
    logic [FIFO_ENTRY_WIDTH-1:0] wr_entry;
    logic [FIFO_ENTRY_WIDTH-1:0] rd_entry;

    assign full  = (count == FIFO_COUNT_WIDTH'(PAYLOAD_FIFO_DEPTH));
    assign empty = (count == '0);

    assign payload_in.tready  = !full;
    assign payload_out.tvalid = !empty;

    assign wr_en = payload_in.tvalid && !full;
    assign rd_en = payload_out.tready && !empty;

    assign wr_entry = {payload_in.tlast, payload_in.tuser, payload_in.tkeep, payload_in.tdata};

    // Head entry shows up the cycle after it is written
    assign rd_entry = mem[rd_ptr];

    assign payload_out.tdata = rd_entry[DATA_WIDTH-1:0];
    assign payload_out.tkeep = rd_entry[DATA_WIDTH +: KEEP_WIDTH];
    assign payload_out.tuser = rd_entry[DATA_WIDTH + KEEP_WIDTH];
    assign payload_out.tlast = rd_entry[DATA_WIDTH + KEEP_WIDTH + 1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap at the power-of-two depth
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({wr_en, rd_en})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    // Simultaneous push and pop keeps the level
                    count <= count;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/udp_port_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module udp_port_filter
    import udp_echo_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  rx_hdr_valid,
    output logic                  rx_hdr_ready,
    input  logic [IP_WIDTH-1:0]   rx_ip_source_ip,
    input  logic [PORT_WIDTH-1:0] rx_source_port,
    input  logic [PORT_WIDTH-1:0] rx_dest_port,
    input  logic [PORT_WIDTH-1:0] rx_length,

    input  logic [DATA_WIDTH-1:0] rx_payload_tdata,
    input  logic [KEEP_WIDTH-1:0] rx_payload_tkeep,
    input  logic                  rx_payload_tvalid,
    output logic                  rx_payload_tready,
    input  logic                  rx_payload_tlast,
    input  logic                  rx_payload_tuser,

    udp_hdr_if.src                hdr_out,
    udp_payload_if.src            payload_out
);

    filter_state_t state;
    filter_state_t state_next;

    logic dest_match;
    logic hdr_xfer;
    logic last_xfer;

    assign dest_match = (rx_dest_port == ECHO_PORT);

    // Headers are only taken between frames
    assign hdr_out.valid = (state == FILTER_IDLE) && rx_hdr_valid && dest_match;
    assign rx_hdr_ready  = (state == FILTER_IDLE) && (dest_match ? hdr_out.ready : 1'b1);

    assign hdr_out.ip_source_ip = rx_ip_source_ip;
    assign hdr_out.source_port  = rx_source_port;
    assign hdr_out.dest_port    = rx_dest_port;
    assign hdr_out.length       = rx_length;

    assign hdr_xfer  = rx_hdr_valid && rx_hdr_ready;
    assign last_xfer = rx_payload_tvalid && rx_payload_tready && rx_payload_tlast;

    // Payload goes to the FIFO in PASS, is swallowed in DROP
    assign payload_out.tvalid = (state == FILTER_PASS) && rx_payload_tvalid;
    assign payload_out.tdata  = rx_payload_tdata;
    assign payload_out.tkeep  = rx_payload_tkeep;
    assign payload_out.tlast  = rx_payload_tlast;
    assign payload_out.tuser  = rx_payload_tuser;

    assign rx_payload_tready = ((state == FILTER_PASS) && payload_out.tready) ||
                               (state == FILTER_DROP);

    always_comb begin
        state_next = state;
        case (state)
            FILTER_IDLE: begin
                // Decision is made once per frame, at the header
                if (hdr_xfer) begin
                    state_next = dest_match ? FILTER_PASS : FILTER_DROP;
                end
            end
            FILTER_PASS, FILTER_DROP: begin
                if (last_xfer) begin
                    state_next = FILTER_IDLE;
                end
            end
            default: begin
                state_next = FILTER_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILTER_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

/* logic/udp_payload_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface udp_payload_if
    import udp_echo_pkg::*;
();

    logic [DATA_WIDTH-1:0] tdata;
    logic [KEEP_WIDTH-1:0] tkeep;
    logic                  tvalid;
    logic                  tready;
    logic                  tlast;
    logic                  tuser;

    // Beat producer
    modport src (
        output tdata,
        output tkeep,
        output tvalid,
        input  tready,
        output tlast,
        output tuser
    );

    // Beat consumer
    modport dst (
        input  tdata,
        input  tkeep,
        input  tvalid,
        output tready,
        input  tlast,
        input  tuser
    );

endinterface

`default_nettype wire

/* logic/udp_hdr_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface udp_hdr_if
    import udp_echo_pkg::*;
();

    logic                  valid;
    logic                  ready;
    logic [IP_WIDTH-1:0]   ip_source_ip;
    logic [PORT_WIDTH-1:0] source_port;
    logic [PORT_WIDTH-1:0] dest_port;
    logic [PORT_WIDTH-1:0] length;

    // Header producer
    modport src (
        output valid,
        input  ready,
        output ip_source_ip,
        output source_port,
        output dest_port,
        output length
    );

    // Header consumer
    modport dst (
        input  valid,
        output ready,
        input  ip_source_ip,
        input  source_port,
        input  dest_port,
        input  length
    );

endinterface

`default_nettype wire

/* logic/udp_echo_pkg.sv */
`default_nettype none

package udp_echo_pkg;

    // Payload stream
    localparam int DATA_WIDTH = 64;
    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    // Header fields
    localparam int PORT_WIDTH = 16;
    localparam int IP_WIDTH   = 32;

    // First payload byte goes to the LEDs
    localparam int LED_WIDTH = 8;

    // Only this destination port gets an echo
    localparam logic [PORT_WIDTH-1:0] ECHO_PORT = 16'd1234;

    // Payload buffer between receive and transmit
    localparam int PAYLOAD_FIFO_DEPTH = 16;

    // Pointers wrap naturally, so depth must stay a power of two
    localparam int FIFO_PTR_WIDTH = $clog2(PAYLOAD_FIFO_DEPTH);

    // One extra bit so a full FIFO can be told from an empty one
    localparam int FIFO_COUNT_WIDTH = FIFO_PTR_WIDTH + 1;

    // Stored beat is {tlast, tuser, tkeep, tdata}
    localparam int FIFO_ENTRY_WIDTH = DATA_WIDTH + KEEP_WIDTH + 2;

    // Per-frame filter decision
    typedef enum logic [1:0] {
        // Waiting for a header
        FILTER_IDLE = 2'd0,
        // Forwarding payload of a matching frame
        FILTER_PASS = 2'd1,
        // Draining payload of a frame for another port
        FILTER_DROP = 2'd2
    } filter_state_t;

endpackage

`default_nettype wire
